/* rv_ex_pkg.sv */
`default_nettype none

package rv_ex_pkg;

    localparam int unsigned xlen  = 32;
    localparam int unsigned rf_aw = 5;  // Register index width.

    // Branch comparison codes, as carried in funct3.
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_slt    = 4'd8,
        alu_sltu   = 4'd9,
        alu_pass_b = 4'd10   // Result is operand b, used for lui.
    } alu_op_e;

    // Operand source, same order as the forwarding mux inputs.
    typedef enum logic [1:0] {
        fwd_rf  = 2'b00,
        fwd_wb  = 2'b01,
        fwd_mem = 2'b10
    } fwd_sel_e;

    typedef struct packed {
        logic             valid;
        alu_op_e          alu_ctrl;
        logic             alu_src;   // Operand b from imm_ext.
        logic [xlen-1:0]  rd1;
        logic [xlen-1:0]  rd2;
        logic [xlen-1:0]  pc;
        logic [xlen-1:0]  imm_ext;
        logic             branch;
        logic             jump;
        logic             jalr;
        logic [2:0]       funct3;
        logic [rf_aw-1:0] rs1;
        logic [rf_aw-1:0] rs2;
        logic [rf_aw-1:0] rd;
        logic             rs1_used;
        logic             rs2_used;
        logic             reg_write;
    } id_ex_t;

    typedef struct packed {
        logic             valid;
        logic [rf_aw-1:0] rd;
        logic             reg_write;
        logic [xlen-1:0]  alu_result;
        logic [xlen-1:0]  write_data;  // Forwarded rs2, kept for the store path.
    } ex_mem_t;

    typedef struct packed {
        logic             valid;
        logic [rf_aw-1:0] rd;
        logic             reg_write;
        logic [xlen-1:0]  result;
    } mem_wb_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [rv_ex_pkg::xlen-1:0] aluop1,
    input  logic [rv_ex_pkg::xlen-1:0] aluop2,
    input  rv_ex_pkg::alu_op_e         aluctrl,
    input  logic [2:0]                 funct3,
    output logic [rv_ex_pkg::xlen-1:0] aluout,
    output logic                       cond
);

    import rv_ex_pkg::*;

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign shamt = aluop2[4:0];   // Only the low five bits shift.
    assign eq    = (aluop1 == aluop2);
    assign lt_s  = ($signed(aluop1) < $signed(aluop2));
    assign lt_u  = (aluop1 < aluop2);

    always_comb begin
        unique case (aluctrl)
            alu_add:    aluout = aluop1 + aluop2;
            alu_sub:    aluout = aluop1 - aluop2;
            alu_and:    aluout = aluop1 & aluop2;
            alu_or:     aluout = aluop1 | aluop2;
            alu_xor:    aluout = aluop1 ^ aluop2;
            alu_sll:    aluout = aluop1 << shamt;
            alu_srl:    aluout = aluop1 >> shamt;
            alu_sra:    aluout = $unsigned($signed(aluop1) >>> shamt);
            alu_slt:    aluout = {{(xlen-1){1'b0}}, lt_s};
            alu_sltu:   aluout = {{(xlen-1){1'b0}}, lt_u};
            alu_pass_b: aluout = aluop2;
            default:    aluout = '0;
        endcase
    end

    // Branch condition from the same operands.
    always_comb begin
        case (funct3)
            f3_beq:  cond = eq;
            f3_bne:  cond = !eq;
            f3_blt:  cond = lt_s;
            f3_bge:  cond = !lt_s;
            f3_bltu: cond = lt_u;
            f3_bgeu: cond = !lt_u;
            default: cond = 1'b0;  // 010 and 011 are not branches.
        endcase
    end

endmodule

`default_nettype wire

/* forward_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module forward_unit (
    input  rv_ex_pkg::id_ex_t  ex_in,
    input  rv_ex_pkg::ex_mem_t mem_q,
    input  rv_ex_pkg::mem_wb_t wb,
    output rv_ex_pkg::fwd_sel_e fwd_rs1,
    output rv_ex_pkg::fwd_sel_e fwd_rs2
);

    import rv_ex_pkg::*;

    // EX/MEM is younger, so it is checked first.
    function automatic fwd_sel_e pick_src(
        input logic [rf_aw-1:0] rs,
        input logic             used,
        input ex_mem_t          m,
        input mem_wb_t          w
    );
        fwd_sel_e sel;
        sel = fwd_rf;
        if (used && (rs != '0)) begin
            if (m.valid && m.reg_write && (m.rd == rs)) begin
                sel = fwd_mem;
            end else if (w.valid && w.reg_write && (w.rd == rs)) begin
                sel = fwd_wb;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwd_rs1 = pick_src(ex_in.rs1, ex_in.rs1_used, mem_q, wb);
        fwd_rs2 = pick_src(ex_in.rs2, ex_in.rs2_used, mem_q, wb);
    end

endmodule

`default_nettype wire

/* execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  rv_ex_pkg::id_ex_t          ex_in,
    input  rv_ex_pkg::fwd_sel_e        fwd_rs1,
    input  rv_ex_pkg::fwd_sel_e        fwd_rs2,
    input  logic [rv_ex_pkg::xlen-1:0] alu_result_m,
    input  logic [rv_ex_pkg::xlen-1:0] result_w,
    output rv_ex_pkg::ex_mem_t         ex_out,
    output rv_ex_pkg::redirect_t       redirect
);

    import rv_ex_pkg::*;

    logic [xlen-1:0] src_a;
    logic [xlen-1:0] fwd_b;      // Forwarded rs2 before the immediate mux.
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] pc_imm;
    logic [xlen-1:0] jalr_target;
    logic            cond;
    logic            take;

    function automatic logic [xlen-1:0] fwd_mux(
        input fwd_sel_e        sel,
        input logic [xlen-1:0] rf_val,
        input logic [xlen-1:0] mem_val,
        input logic [xlen-1:0] wb_val
    );
        logic [xlen-1:0] v;
        case (sel)
            fwd_mem: v = mem_val;
            fwd_wb:  v = wb_val;
            default: v = rf_val;
        endcase
        return v;
    endfunction

    assign src_a = fwd_mux(fwd_rs1, ex_in.rd1, alu_result_m, result_w);
    assign fwd_b = fwd_mux(fwd_rs2, ex_in.rd2, alu_result_m, result_w);
    assign src_b = ex_in.alu_src ? ex_in.imm_ext : fwd_b;

    alu u_alu (
        .aluop1  (src_a),
        .aluop2  (src_b),
        .aluctrl (ex_in.alu_ctrl),
        .funct3  (ex_in.funct3),
        .aluout  (alu_res),
        .cond    (cond)
    );

    assign pc_imm      = ex_in.pc + ex_in.imm_ext;
    assign jalr_target = {alu_res[xlen-1:1], 1'b0};  // rs1 + imm, low bit cleared.

    assign take = ex_in.jump || (ex_in.branch && cond);

    always_comb begin
        redirect.valid  = ex_in.valid && take;
        redirect.target = ex_in.jalr ? jalr_target : pc_imm;
    end

    always_comb begin
        ex_out.valid      = ex_in.valid;
        ex_out.rd         = ex_in.rd;
        ex_out.reg_write  = ex_in.reg_write;
        ex_out.alu_result = alu_res;
        ex_out.write_data = fwd_b;
    end

endmodule

`default_nettype wire

/* pipe_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = rv_ex_pkg::mem_wb_t
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Flush kills the entry but keeps its payload bits.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q <= '0;
        end else begin
            q <= d;
            if (flush) begin
                q.valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* ex_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_ex_pkg::id_ex_t    issue,
    output rv_ex_pkg::redirect_t redirect,
    output rv_ex_pkg::mem_wb_t   wb
);

    import rv_ex_pkg::*;

    id_ex_t   ex_in;
    ex_mem_t  ex_out;
    ex_mem_t  mem_q;
    mem_wb_t  mem_d;    // MEM stage output, no memory access here.
    fwd_sel_e fwd_rs1;
    fwd_sel_e fwd_rs2;

    // A redirect kills the instruction entering EX behind it.
    pipe_stage #(.payload_t(id_ex_t)) u_id_ex (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (redirect.valid),
        .d     (issue),
        .q     (ex_in)
    );

    forward_unit u_fwd (
        .ex_in   (ex_in),
        .mem_q   (mem_q),
        .wb      (wb),
        .fwd_rs1 (fwd_rs1),
        .fwd_rs2 (fwd_rs2)
    );

    execute u_ex (
        .ex_in        (ex_in),
        .fwd_rs1      (fwd_rs1),
        .fwd_rs2      (fwd_rs2),
        .alu_result_m (mem_q.alu_result),
        .result_w     (wb.result),
        .ex_out       (ex_out),
        .redirect     (redirect)
    );

    pipe_stage #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (1'b0),
        .d     (ex_out),
        .q     (mem_q)
    );

    always_comb begin
        mem_d.valid     = mem_q.valid;
        mem_d.rd        = mem_q.rd;
        mem_d.reg_write = mem_q.reg_write;
        mem_d.result    = mem_q.alu_result;  // No loads, so the ALU result is final.
    end

    pipe_stage #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (1'b0),
        .d     (mem_d),
        .q     (wb)
    );

endmodule

`default_nettype wire

/* tb_ex_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ex_pipe;

    import rv_ex_pkg::*;

    logic      clk = 1'b0;
    logic      rst_n;
    id_ex_t    issue;
    redirect_t redirect;
    mem_wb_t   wb;

    logic [xlen-1:0] rf [32];    // Updated from wb only.
    logic [xlen-1:0] arch [32];  // Architectural state at issue.
    int              cyc = 0;
    int              taken_cyc = -10;
    string           test_name = "reset";
    int              wq_cyc[$];
    logic [4:0]      wq_rd[$];
    logic [xlen-1:0] wq_val[$];
    int              rq_cyc[$];
    logic [xlen-1:0] rq_tgt[$];

    ex_pipe_top UUT (.clk(clk), .rst_n(rst_n), .issue(issue), .redirect(redirect), .wb(wb));

    always #4 clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;

    task automatic fail_msg(input string why);
        $display("Error in %s: %s", test_name, why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_eq(input string what, input logic [xlen-1:0] exp,
                            input logic [xlen-1:0] act);
        if (exp !== act) begin
            $display("Fail %s (%s): expected %h, actual %h", test_name, what, exp, act);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    function automatic logic [xlen-1:0] alu_model(input alu_op_e op, input logic [xlen-1:0] a,
                                                  input logic [xlen-1:0] b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return $unsigned($signed(a) >>> b[4:0]);
            alu_slt:  return ($signed(a) < $signed(b)) ? 1 : 0;
            alu_sltu: return (a < b) ? 1 : 0;
            default:  return b;   // pass_b
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [xlen-1:0] a,
                                          input logic [xlen-1:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic id_ex_t mk(input alu_op_e op, input logic src, input logic [4:0] rs1,
                                  input logic [4:0] rs2, input logic [4:0] rd,
                                  input logic [xlen-1:0] imm, input logic u1, input logic u2);
        id_ex_t r;
        r = '0;
        r.valid = 1'b1;
        r.alu_ctrl = op;
        r.alu_src = src;
        r.rs1 = rs1;
        r.rs2 = rs2;
        r.rd = rd;
        r.imm_ext = imm;
        r.rs1_used = u1;
        r.rs2_used = u2;
        r.reg_write = 1'b1;
        return r;
    endfunction

    // Drives one instruction and records what it must produce.
    task automatic send(input id_ex_t ins);
        int              k;
        logic            killed;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] res;
        @(posedge clk);
        k = cyc;
        killed = (k == taken_cyc + 1);   // Shadow of a redirect.
        ins.rd1 = rf[ins.rs1];
        ins.rd2 = rf[ins.rs2];
        a = ins.rs1_used ? arch[ins.rs1] : ins.rd1;
        b = ins.rs2_used ? arch[ins.rs2] : ins.rd2;
        res = alu_model(ins.alu_ctrl, a, ins.alu_src ? ins.imm_ext : b);
        if (!killed) begin
            if (ins.reg_write) begin
                wq_cyc.push_back(k + 4);
                wq_rd.push_back(ins.rd);
                wq_val.push_back(res);
                if (ins.rd != 0) arch[ins.rd] = res;
            end
            if (ins.jump || (ins.branch && branch_taken(ins.funct3, a, b))) begin
                rq_cyc.push_back(k + 2);
                rq_tgt.push_back(ins.jalr ? (res & ~32'd1) : ins.pc + ins.imm_ext);
                taken_cyc = k;
            end
        end
        issue <= ins;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            issue <= '0;
        end
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while ((wq_cyc.size() != 0 || rq_cyc.size() != 0) && t < 40) begin
            @(posedge clk);
            t++;
        end
        if (wq_cyc.size() != 0 || rq_cyc.size() != 0) begin
            fail_msg("timed out waiting for pending writebacks and redirects");
        end
    endtask

    // Outputs are checked at the falling edge.
    always @(negedge clk) begin
        if (!rst_n) begin
            if (redirect.valid || wb.valid) fail_msg("output valid while reset is asserted");
        end else begin
            if (redirect.valid) begin
                if (rq_cyc.size() == 0) begin
                    fail_msg("unexpected redirect");
                end else begin
                    check_eq("redirect cycle", rq_cyc.pop_front(), cyc);
                    check_eq("redirect target", rq_tgt.pop_front(), redirect.target);
                end
            end else if (rq_cyc.size() != 0 && rq_cyc[0] <= cyc) begin
                fail_msg("expected redirect did not appear");
            end
            if (wb.valid && wb.reg_write) begin
                if (wq_cyc.size() == 0) begin
                    fail_msg("unexpected writeback");
                end else begin
                    check_eq("wb cycle", wq_cyc.pop_front(), cyc);
                    check_eq("wb rd", wq_rd.pop_front(), wb.rd);
                    check_eq("wb result", wq_val.pop_front(), wb.result);
                    if (wb.rd != 0) rf[wb.rd] = wb.result;
                end
            end else if (wq_cyc.size() != 0 && wq_cyc[0] <= cyc) begin
                fail_msg("expected writeback did not appear");
            end
        end
    end

    task automatic test_alu_ops();
        id_ex_t ins;
        test_name = "alu_ops";
        for (int i = 0; i < 22; i++) begin
            ins = mk(alu_op_e'(i % 11), i >= 11, 5'(1 + i % 9), 5'(10 + i % 7), 5'(20 + i % 11),
                     $urandom, 1'b1, i < 11);
            send(ins);
            idle(3);
        end
        wait_drain();
    endtask

    task automatic test_forwarding();
        test_name = "forwarding";
        send(mk(alu_add, 0, 1, 2, 5, 0, 1, 1));
        send(mk(alu_add, 0, 5, 3, 5, 0, 1, 1));   // Distance 1 on rs1.
        send(mk(alu_or, 0, 5, 5, 6, 0, 1, 1));    // Both stages hold x5.
        send(mk(alu_sub, 0, 6, 5, 7, 0, 1, 1));   // rs1 from EX/MEM, rs2 from MEM/WB.
        idle(4);
        send(mk(alu_add, 0, 2, 3, 9, 0, 1, 1));
        send(mk(alu_sltu, 0, 4, 9, 10, 0, 1, 1)); // Distance 1 on rs2.
        idle(4);
        wait_drain();
    endtask

    task automatic test_no_forward();
        test_name = "no_forward";
        send(mk(alu_add, 0, 1, 2, 0, 0, 1, 1));   // Write to x0 is dropped.
        send(mk(alu_add, 0, 0, 0, 11, 0, 1, 1));
        idle(4);
        send(mk(alu_add, 0, 3, 4, 12, 0, 1, 1));
        send(mk(alu_add, 0, 12, 12, 13, 0, 0, 0)); // Unused sources read the stale x12.
        idle(4);
        wait_drain();
    endtask

    task automatic test_branches();
        logic [2:0]      f3s [6];
        logic [xlen-1:0] av [3];
        logic [xlen-1:0] bv [3];
        id_ex_t          ins;
        f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        av = '{32'd5, -32'sd3, 32'd7};
        bv = '{32'd5, 32'd7, -32'sd3};
        test_name = "branches";
        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 3; p++) begin
                send(mk(alu_pass_b, 1, 0, 0, 14, av[p], 0, 0));
                send(mk(alu_pass_b, 1, 0, 0, 15, bv[p], 0, 0));
                ins = mk(alu_add, 0, 14, 15, 0, 32'h40 + 8 * p, 1, 1);
                ins.reg_write = 1'b0;
                ins.branch = 1'b1;
                ins.funct3 = f3s[f];
                ins.pc = 32'h1000 + 32'(f * 16 + p * 4);
                send(ins);
                send(mk(alu_add, 0, 1, 2, 20, 0, 1, 1));  // Killed when taken.
                idle(4);
            end
        end
        wait_drain();
    endtask

    task automatic test_jumps();
        id_ex_t jal;
        id_ex_t jr;
        test_name = "jumps";
        jal = mk(alu_add, 1, 0, 0, 0, 32'h0000_0200, 0, 0);
        jal.reg_write = 1'b0;
        jal.jump = 1'b1;
        jal.pc = 32'h0000_2000;
        send(jal);
        send(mk(alu_add, 0, 1, 2, 16, 0, 1, 1));   // Shadow.
        send(mk(alu_add, 0, 16, 3, 17, 0, 1, 1));  // Killed x16 sits in EX/MEM.
        send(mk(alu_add, 0, 3, 16, 18, 0, 1, 1));  // Killed x16 sits in MEM/WB.
        idle(4);
        jr = jal;
        jr.jalr = 1'b1;
        jr.rs1 = 5'd2;
        jr.rs1_used = 1'b1;
        jr.imm_ext = 32'h100 | (~arch[2] & 32'd1);  // Sum is odd.
        send(jr);
        send(jal);                                   // Shadow jump must not redirect.
        send(mk(alu_xor, 0, 2, 3, 19, 0, 1, 1));
        idle(4);
        wait_drain();
    endtask

    initial begin
        void'($urandom(32'h4b40_b8df));
        for (int i = 0; i < 32; i++) begin
            rf[i] = (i == 0) ? '0 : $urandom;
            arch[i] = rf[i];
        end
        rst_n = 1'b0;
        issue = '0;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            if (i == 7) begin
                rst_n <= 1'b1;
                issue <= '0;
            end else begin
                issue <= mk(alu_add, 1, 0, 0, 3, 32'(i), 0, 0);
                issue.jump <= 1'b1;
            end
        end
        idle(4);   // Nothing driven in reset may come out.
        test_alu_ops();
        test_forwarding();
        test_no_forward();
        test_branches();
        test_jumps();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
rv_ex_pkg.sv
alu.sv
forward_unit.sv
execute.sv
pipe_stage.sv
ex_pipe_top.sv
tb_ex_pipe.sv

/* Bender.yml */
package:
  name: ex_pipe

sources:
  - rv_ex_pkg.sv
  - alu.sv
  - forward_unit.sv
  - execute.sv
  - pipe_stage.sv
  - ex_pipe_top.sv
  - target: test
    files:
      - tb_ex_pipe.sv
